//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -sv --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+include
src/bus_pkg.sv
src/io_pkg.sv
src/mem_arbiter.sv
src/sram_store.sv
src/io_decode.sv
src/config_reg.sv
src/soc_bus_top.sv
tb/tb_soc_bus.sv

//--- include/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// Word address, covering byte address bits 19 to 1.
`define BUS_ADDR_W 19

`define BUS_DATA_W 16

// On-chip RAM depth in words. Only the low address bits select a word.
`define MEM_WORDS 1024

// Port address of the configuration register in I/O space.
`define IO_CONFIG_PORT 16'hfffc

`endif

//--- src/bus_pkg.sv
`default_nettype none

`include "bus_settings.svh"

package bus_pkg;

    // One request on the memory bus. The master holds every field steady
    // while access is high and until it has seen ack.
    typedef struct packed {
        logic                        access;
        logic                        wr_en;
        logic [`BUS_DATA_W/8-1:0]    bytesel;
        logic [`BUS_ADDR_W-1:0]      addr;
        logic [`BUS_DATA_W-1:0]      wdata;
    } bus_req_t;

    // Response to a memory-bus request. Ack is a single-cycle pulse and rdata
    // is only meaningful while it is high.
    typedef struct packed {
        logic                        ack;
        logic [`BUS_DATA_W-1:0]      rdata;
    } bus_rsp_t;

    // Arbiter states for the shared memory bus.
    typedef enum logic [1:0] {
        idle,
        serve_instr,
        serve_data
    } arb_state_e;

endpackage

`default_nettype wire

//--- src/config_reg.sv
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module config_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  io_pkg::io_req_t        cfg_req,
    output logic                   cfg_ack,
    output logic [`BUS_DATA_W-1:0] cfg_rdata
);
    logic [`BUS_DATA_W-1:0] value_q;
    logic                   ack_q;
    logic                   start;

    assign start = cfg_req.access && !ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            value_q <= '0;
        end else begin
            ack_q <= start;
            if (start && cfg_req.wr_en) begin
                value_q <= cfg_req.wdata;
            end
        end
    end

    assign cfg_ack = ack_q;

    // Quiet outside the ack cycle so the decoder can OR the read data.
    assign cfg_rdata = ack_q ? value_q : '0;

endmodule

`default_nettype wire

//--- src/io_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module io_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  io_pkg::io_req_t        io_req,
    output io_pkg::io_req_t        cfg_req,
    input  logic                   cfg_ack,
    input  logic [`BUS_DATA_W-1:0] cfg_rdata,
    output bus_pkg::bus_rsp_t      io_rsp
);
    import io_pkg::*;

    io_port_e port_sel;
    logic     default_access;
    logic     default_ack;

    always_comb begin
        case (io_req.addr)
            `IO_CONFIG_PORT: port_sel = port_config;
            default:         port_sel = port_none;
        endcase
    end

    // Only the selected device sees the strobe.
    always_comb begin
        cfg_req        = io_req;
        cfg_req.access = io_req.access && (port_sel == port_config);
    end

    assign default_access = io_req.access && (port_sel == port_none);

    // Unmapped ports still complete so a stray access cannot hang the master.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            default_ack <= 1'b0;
        end else begin
            default_ack <= default_access && !default_ack;
        end
    end

    // Each device drives zero when it is not acking, so an OR merges them.
    // The default responder reads as zero and adds nothing to rdata.
    always_comb begin
        io_rsp.ack   = cfg_ack | default_ack;
        io_rsp.rdata = cfg_rdata;
    end

endmodule

`default_nettype wire

//--- src/io_pkg.sv
`default_nettype none

`include "bus_settings.svh"

package io_pkg;

    // Devices that an I/O access can land on.
    // Anything unmapped goes to the default responder.
    typedef enum logic {
        port_config,
        port_none
    } io_port_e;

    // An I/O request as seen by the decoder and the devices behind it.
    // The port address is a byte address with bit 0 always clear.
    typedef struct packed {
        logic                        access;
        logic                        wr_en;
        logic [15:0]                 addr;
        logic [`BUS_DATA_W-1:0]      wdata;
    } io_req_t;

endpackage

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t instr_req,
    input  bus_pkg::bus_req_t data_req,
    output bus_pkg::bus_rsp_t instr_rsp,
    output bus_pkg::bus_rsp_t data_rsp,
    output bus_pkg::bus_req_t mem_req,
    input  bus_pkg::bus_rsp_t mem_rsp
);
    import bus_pkg::*;

    arb_state_e state;
    arb_state_e state_next;
    logic       last_data;

    // A tie goes to whichever master was not served last. After reset the
    // instruction port counts as last served, so data wins the first tie.
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (instr_req.access && data_req.access) begin
                    state_next = last_data ? serve_instr : serve_data;
                end else if (data_req.access) begin
                    state_next = serve_data;
                end else if (instr_req.access) begin
                    state_next = serve_instr;
                end
            end
            serve_instr, serve_data: begin
                if (mem_rsp.ack) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            last_data <= 1'b0;
        end else begin
            state <= state_next;
            if (state_next != idle) begin
                last_data <= (state_next == serve_data);
            end
        end
    end

    // The granted request goes through and the response returns to its owner.
    // The fetch port never writes.
    always_comb begin
        mem_req   = '0;
        instr_rsp = '0;
        data_rsp  = '0;
        case (state)
            serve_instr: begin
                mem_req       = instr_req;
                mem_req.wr_en = 1'b0;
                instr_rsp     = mem_rsp;
            end
            serve_data: begin
                mem_req  = data_req;
                data_rsp = mem_rsp;
            end
            default: ;
        endcase
    end

    ack_in_serve: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.ack |-> (state != idle));

    // The owning master has to hold its request until the transfer is acked.
    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (state != idle && !mem_rsp.ack) |=> $stable(mem_req));

endmodule

`default_nettype wire

//--- src/soc_bus_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module soc_bus_top (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t instr_req,
    input  bus_pkg::bus_req_t data_req,
    input  logic              d_io,
    output bus_pkg::bus_rsp_t instr_rsp,
    output bus_pkg::bus_rsp_t data_rsp
);
    import bus_pkg::*;
    import io_pkg::*;

    bus_req_t               data_mem_req;
    bus_rsp_t               data_mem_rsp;
    bus_req_t               mem_req;
    bus_rsp_t               mem_rsp;
    io_req_t                io_req;
    io_req_t                cfg_req;
    bus_rsp_t               io_rsp;
    logic                   cfg_ack;
    logic [`BUS_DATA_W-1:0] cfg_rdata;

    // The I/O flag picks memory or I/O space for the data port.
    always_comb begin
        data_mem_req        = data_req;
        data_mem_req.access = data_req.access && !d_io;

        io_req.access = data_req.access && d_io;
        io_req.wr_en  = data_req.wr_en;
        io_req.addr   = {data_req.addr[14:0], 1'b0};
        io_req.wdata  = data_req.wdata;
    end

    // Only one side acks at a time and the idle side drives zero.
    always_comb begin
        data_rsp.ack   = data_mem_rsp.ack | io_rsp.ack;
        data_rsp.rdata = data_mem_rsp.rdata | io_rsp.rdata;
    end

    mem_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_req (instr_req),
        .data_req  (data_mem_req),
        .instr_rsp (instr_rsp),
        .data_rsp  (data_mem_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    sram_store u_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    io_decode u_io_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .io_req    (io_req),
        .cfg_req   (cfg_req),
        .cfg_ack   (cfg_ack),
        .cfg_rdata (cfg_rdata),
        .io_rsp    (io_rsp)
    );

    config_reg u_config_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_req   (cfg_req),
        .cfg_ack   (cfg_ack),
        .cfg_rdata (cfg_rdata)
    );

endmodule

`default_nettype wire

//--- src/sram_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module sram_store (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t mem_req,
    output bus_pkg::bus_rsp_t mem_rsp
);
    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int LANES = `BUS_DATA_W / 8;

    logic [`BUS_DATA_W-1:0] mem [`MEM_WORDS];
    logic [`BUS_DATA_W-1:0] rdata_q;
    logic                   ack_q;
    logic                   start;
    logic [IDX_W-1:0]       idx;

    // An access starts once per strobe. The cycle with ack high is skipped so a
    // held request is not served twice.
    assign start = mem_req.access && !ack_q;
    assign idx   = mem_req.addr[IDX_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (mem_req.wr_en) begin
                for (int b = 0; b < LANES; b++) begin
                    if (mem_req.bytesel[b]) begin
                        mem[idx][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    assign mem_rsp.ack   = ack_q;
    assign mem_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

//--- tb/tb_soc_bus.sv
`timescale 1ns/1ns
`default_nettype none

`include "bus_settings.svh"

module tb_soc_bus;
    import bus_pkg::*;

    localparam int                     NFETCH     = 24;
    localparam int                     IDX_W      = $clog2(`MEM_WORDS);
    localparam logic [`BUS_ADDR_W-1:0] FETCH_BASE = 19'h00200;

    // One data-port operation and the value that a read should return.
    typedef struct packed {
        logic                   io;
        logic                   wr;
        logic [1:0]             bytesel;
        logic [`BUS_ADDR_W-1:0] addr;
        logic [`BUS_DATA_W-1:0] wdata;
        logic [`BUS_DATA_W-1:0] exp_data;
    } row_t;

    logic     clk;
    logic     rst_n;
    bus_req_t instr_req;
    bus_req_t data_req;
    logic     d_io;
    bus_rsp_t instr_rsp;
    bus_rsp_t data_rsp;

    row_t                   rows[$];
    logic [`BUS_DATA_W-1:0] ref_mem [`MEM_WORDS];
    logic [`BUS_DATA_W-1:0] cfg_model;
    int                     check_count;
    int                     err_count;
    int                     fetch_start_row;
    logic                   table_ready;
    logic                   fetch_go;
    logic                   fetch_done;
    integer                 seed = 32'hcce4126e;

    soc_bus_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_req (instr_req),
        .data_req  (data_req),
        .d_io      (d_io),
        .instr_rsp (instr_rsp),
        .data_rsp  (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // Applies one operation to the memory and I/O models and queues it.
    function automatic void add_row(input logic io, input logic wr, input logic [1:0] sel,
                                    input logic [`BUS_ADDR_W-1:0] addr,
                                    input logic [`BUS_DATA_W-1:0] wdata);
        row_t             r;
        logic [IDX_W-1:0] idx;
        logic [15:0]      port;
        r = '{io: io, wr: wr, bytesel: sel, addr: addr, wdata: wdata, exp_data: '0};
        idx  = addr[IDX_W-1:0];
        port = {addr[14:0], 1'b0};
        if (io) begin
            if (port == `IO_CONFIG_PORT) begin
                if (wr) cfg_model = wdata;
                else r.exp_data = cfg_model;
            end
        end else if (wr) begin
            for (int b = 0; b < 2; b++) begin
                if (sel[b]) ref_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end else begin
            r.exp_data = ref_mem[idx];
        end
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        cfg_model = '0;
        add_row(1'b1, 1'b0, 2'b11, 19'h07ffe, 16'h0000);
        for (int i = 0; i < 8; i++) begin
            add_row(1'b0, 1'b1, 2'b11, FETCH_BASE + 19'(i), 16'h1000 + 16'(i) * 16'h0111);
        end
        // Fetches start here and only read the region written above.
        fetch_start_row = rows.size();
        add_row(1'b0, 1'b1, 2'b11, 19'h00010, 16'ha5c3);
        add_row(1'b0, 1'b0, 2'b11, 19'h00010, 16'h0000);
        add_row(1'b0, 1'b1, 2'b11, 19'h00011, 16'h1234);
        add_row(1'b0, 1'b1, 2'b10, 19'h00011, 16'hbeef);
        add_row(1'b0, 1'b0, 2'b11, 19'h00011, 16'h0000);
        add_row(1'b0, 1'b1, 2'b01, 19'h00010, 16'h0077);
        add_row(1'b0, 1'b0, 2'b11, 19'h00010, 16'h0000);
        add_row(1'b0, 1'b1, 2'b11, 19'h07ffe, 16'h5a5a);
        add_row(1'b1, 1'b1, 2'b11, 19'h07ffe, 16'hc0de);
        add_row(1'b1, 1'b0, 2'b11, 19'h07ffe, 16'h0000);
        add_row(1'b0, 1'b0, 2'b11, 19'h07ffe, 16'h0000);
        add_row(1'b1, 1'b1, 2'b11, 19'h00100, 16'hffff);
        add_row(1'b1, 1'b0, 2'b11, 19'h00100, 16'h0000);
        add_row(1'b1, 1'b0, 2'b11, 19'h07ffe, 16'h0000);
        add_row(1'b0, 1'b0, 2'b11, FETCH_BASE + 19'd3, 16'h0000);
    endfunction

    task automatic run_row(input row_t r);
        @(posedge clk);
        d_io     <= r.io;
        data_req <= '{access: 1'b1, wr_en: r.wr, bytesel: r.bytesel, addr: r.addr,
                      wdata: r.wdata};
        @(negedge clk);
        while (!data_rsp.ack) @(negedge clk);
        if (!r.wr) check("data_rsp.rdata", r.exp_data, data_rsp.rdata);
        @(posedge clk);
        data_req.access <= 1'b0;
        @(negedge clk);
        check("data_rsp.ack", 16'd0, 16'(data_rsp.ack));
    endtask

    initial begin : main_flow
        int errs_before;
        instr_req   = '0;
        data_req    = '0;
        d_io        = 1'b0;
        rst_n       = 1'b0;
        check_count = 0;
        err_count   = 0;
        fetch_go    = 1'b0;
        fetch_done  = 1'b0;
        build_table();
        table_ready = 1'b1;

        // Both acks stay low through reset and the first cycles after it.
        repeat (2) begin
            @(negedge clk);
            check("instr_rsp.ack", 16'd0, 16'(instr_rsp.ack));
            check("data_rsp.ack", 16'd0, 16'(data_rsp.ack));
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check("instr_rsp.ack", 16'd0, 16'(instr_rsp.ack));
            check("data_rsp.ack", 16'd0, 16'(data_rsp.ack));
        end
        $display("reset: %s", (err_count == 0) ? "ok" : "mismatch");

        for (int i = 0; i < rows.size(); i++) begin
            if (i == fetch_start_row) fetch_go = 1'b1;
            errs_before = err_count;
            run_row(rows[i]);
            $display("row %0d %s %s addr %h: %s", i, rows[i].io ? "io" : "mem",
                     rows[i].wr ? "write" : "read", rows[i].addr,
                     (err_count == errs_before) ? "ok" : "mismatch");
        end

        wait (fetch_done === 1'b1);
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : fetch_stream
        logic [`BUS_ADDR_W-1:0] faddr;
        int                     rnd;
        wait (fetch_go === 1'b1);
        for (int i = 0; i < NFETCH; i++) begin
            rnd   = $random(seed);
            faddr = FETCH_BASE + {16'd0, rnd[2:0]};
            @(posedge clk);
            instr_req <= '{access: 1'b1, wr_en: 1'b0, bytesel: 2'b11, addr: faddr,
                           wdata: '0};
            @(negedge clk);
            while (!instr_rsp.ack) @(negedge clk);
            check("instr_rsp.rdata", ref_mem[faddr[IDX_W-1:0]], instr_rsp.rdata);
            @(posedge clk);
            instr_req.access <= 1'b0;
            @(negedge clk);
            check("instr_rsp.ack", 16'd0, 16'(instr_rsp.ack));
        end
        $display("fetch stream: %0d reads done", NFETCH);
        fetch_done = 1'b1;
    end

    initial begin : watchdog
        int cycles;
        int limit;
        cycles = 0;
        wait (table_ready === 1'b1);
        limit = 20 * (rows.size() + NFETCH);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
